/* src/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// physical address and data word
`define CACHE_ADDR_BITS 32
`define CACHE_WORD_BITS 32

// 16 sets of 4-word lines
`define CACHE_SET_BITS 4
`define CACHE_OFS_BITS 2
`define CACHE_WAYS     4

// what is left above set index and word offset
`define CACHE_TAG_BITS (`CACHE_ADDR_BITS - 2 - `CACHE_OFS_BITS - `CACHE_SET_BITS)

`endif

/* src/cache_pkg.sv */
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_BITS-1:0] paddr_t;
    typedef logic [`CACHE_WORD_BITS-1:0] word_t;
    typedef logic [`CACHE_TAG_BITS-1:0]  tag_t;
    typedef logic [`CACHE_SET_BITS-1:0]  set_idx_t;
    typedef logic [`CACHE_OFS_BITS-1:0]  word_idx_t;
    typedef logic [`CACHE_WAYS-1:0]      way_mask_t;
    typedef logic [3:0]                  byte_en_t;
    // bit 0 picks the pair, bit 1 within ways 0/1, bit 2 within ways 2/3
    typedef logic [2:0]                  plru_t;

    // one storage access, read and optional writes
    typedef struct packed {
        logic      req;
        set_idx_t  set;
        word_idx_t word;
        way_mask_t data_we;
        byte_en_t  byte_en;
        word_t     wdata;
        way_mask_t tag_we;
        tag_t      tag;
        logic      valid;
        way_mask_t dirty_we;
        logic      dirty;
        logic      hist_we;
        plru_t     hist;
    } store_req_t;

    // everything one set read returns
    typedef struct packed {
        word_t [`CACHE_WAYS-1:0] rdata;
        tag_t  [`CACHE_WAYS-1:0] tag;
        way_mask_t               valid;
        way_mask_t               dirty;
        plru_t                   hist;
    } store_rsp_t;

    // burst memory port, cache side
    typedef struct packed {
        logic   arvalid;
        paddr_t araddr;
        logic   rready;
        logic   awvalid;
        paddr_t awaddr;
        logic   wvalid;
        word_t  wdata;
        logic   wlast;
        logic   bready;
    } mem_req_t;

    // burst memory port, memory side
    typedef struct packed {
        logic  arready;
        logic  rvalid;
        word_t rdata;
        logic  rlast;
        logic  awready;
        logic  wready;
        logic  bvalid;
    } mem_rsp_t;

    typedef enum logic [3:0] {
        MS_IDLE,
        MS_LOOKUP,
        MS_WB_ADDR,
        MS_WB_DATA,
        MS_WB_RESP,
        MS_RF_ADDR,
        MS_RF_DATA,
        MS_INSTALL,
        MS_DONE
    } miss_state_t;

endpackage

`default_nettype wire

/* src/cache_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_store (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire cache_pkg::store_req_t st_req,
    output cache_pkg::store_rsp_t      st_rsp
);
    import cache_pkg::*;

    localparam int SETS       = 1 << `CACHE_SET_BITS;
    localparam int LINE_WORDS = 1 << `CACHE_OFS_BITS;

    word_t     data_q  [`CACHE_WAYS][SETS*LINE_WORDS];
    tag_t      tag_q   [`CACHE_WAYS][SETS];
    way_mask_t valid_q [SETS];
    way_mask_t dirty_q [SETS];
    plru_t     hist_q  [SETS];

    logic [`CACHE_SET_BITS+`CACHE_OFS_BITS-1:0] word_addr;

    assign word_addr = {st_req.set, st_req.word};

    // data words with byte enables, tags per way
    always_ff @(posedge clk) begin
        if (st_req.req) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                for (int b = 0; b < $bits(byte_en_t); b++) begin
                    if (st_req.data_we[w] && st_req.byte_en[b])
                        data_q[w][word_addr][8*b +: 8] <= st_req.wdata[8*b +: 8];
                end
                if (st_req.tag_we[w])
                    tag_q[w][st_req.set] <= st_req.tag;
            end
        end
    end

    // valid, dirty and history start cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                hist_q[s]  <= '0;
            end
        end else if (st_req.req) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                // valid travels with the tag write
                if (st_req.tag_we[w])
                    valid_q[st_req.set][w] <= st_req.valid;
                if (st_req.dirty_we[w])
                    dirty_q[st_req.set][w] <= st_req.dirty;
            end
            if (st_req.hist_we)
                hist_q[st_req.set] <= st_req.hist;
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (st_req.req) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                st_rsp.rdata[w] <= data_q[w][word_addr];
                st_rsp.tag[w]   <= tag_q[w][st_req.set];
            end
            st_rsp.valid <= valid_q[st_req.set];
            st_rsp.dirty <= dirty_q[st_req.set];
            st_rsp.hist  <= hist_q[st_req.set];
        end
    end

endmodule

`default_nettype wire

/* src/store_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module store_arbiter (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire cache_pkg::store_req_t fe_req,
    input  wire cache_pkg::store_req_t mh_req,
    output logic                       fe_grant,
    output logic                       mh_grant,
    output cache_pkg::store_rsp_t      fe_rsp,
    output cache_pkg::store_rsp_t      mh_rsp,
    output cache_pkg::store_req_t      st_req,
    input  wire cache_pkg::store_rsp_t st_rsp
);
    logic fe_own_q;
    logic mh_own_q;

    // miss handler always wins
    assign mh_grant = mh_req.req;
    assign fe_grant = fe_req.req && !mh_req.req;
    assign st_req   = mh_req.req ? mh_req : fe_req;

    // who owns the read data coming back next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fe_own_q <= 1'b0;
            mh_own_q <= 1'b0;
        end else begin
            fe_own_q <= fe_grant;
            mh_own_q <= mh_grant;
        end
    end

    // the peer that did not read sees all-zero valid bits
    assign fe_rsp = fe_own_q ? st_rsp : '0;
    assign mh_rsp = mh_own_q ? st_rsp : '0;

    // the handler only works while the front end waits on a miss
    assert property (@(posedge clk) disable iff (!rst_n) !(fe_req.req && mh_req.req));

endmodule

`default_nettype wire

/* src/cache_frontend.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_frontend (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        en,
    input  wire cache_pkg::paddr_t     addr,
    input  wire cache_pkg::byte_en_t   wen,
    input  wire cache_pkg::word_t      wdata,
    output cache_pkg::word_t           rdata,
    output logic                       stall,
    output cache_pkg::store_req_t      fe_req,
    input  wire                        fe_grant,
    input  wire cache_pkg::store_rsp_t fe_rsp,
    output logic                       miss_req,
    output cache_pkg::paddr_t          miss_addr,
    output cache_pkg::byte_en_t        miss_wen,
    output cache_pkg::word_t           miss_wdata,
    input  wire                        miss_done
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_LOOKUP,
        FE_MISS
    } fe_state_t;

    fe_state_t  state_q;
    fe_state_t  state_d;
    tag_t       req_tag;
    set_idx_t   req_set;
    word_idx_t  req_word;
    way_mask_t  hit_vec;
    logic [1:0] hit_way;
    logic       hit;
    logic       done;
    plru_t      hist_new;

    assign req_tag  = addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign req_set  = addr[2+`CACHE_OFS_BITS +: `CACHE_SET_BITS];
    assign req_word = addr[2 +: `CACHE_OFS_BITS];

    // compare all ways of the set read last cycle
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = fe_rsp.valid[w] && (fe_rsp.tag[w] == req_tag);
            if (hit_vec[w])
                hit_way = 2'(w);
        end
    end

    assign hit  = (state_q == FE_LOOKUP) && (|hit_vec);
    assign done = hit && fe_grant;

    // point the tree away from the way just used
    always_comb begin
        hist_new = fe_rsp.hist;
        if (hit_way[1]) begin
            hist_new[0] = 1'b0;
            hist_new[2] = ~hit_way[0];
        end else begin
            hist_new[0] = 1'b1;
            hist_new[1] = ~hit_way[0];
        end
    end

    always_comb begin
        fe_req         = '0;
        fe_req.set     = req_set;
        fe_req.word    = req_word;
        fe_req.byte_en = wen;
        fe_req.wdata   = wdata;
        fe_req.dirty   = 1'b1;
        fe_req.hist    = hist_new;
        if (state_q == FE_IDLE) begin
            fe_req.req = en;
        end else if (hit) begin
            // write bytes, set dirty and history in the hit cycle
            fe_req.req     = 1'b1;
            fe_req.hist_we = 1'b1;
            if (|wen) begin
                fe_req.data_we  = hit_vec;
                fe_req.dirty_we = hit_vec;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FE_IDLE: begin
                if (en && fe_grant)
                    state_d = FE_LOOKUP;
            end
            // an ungranted hit falls back to idle and reads again
            FE_LOOKUP: state_d = (|hit_vec) ? FE_IDLE : FE_MISS;
            FE_MISS: begin
                if (miss_done)
                    state_d = FE_IDLE;
            end
            default: state_d = FE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= FE_IDLE;
        else
            state_q <= state_d;
    end

    assign stall = en && !done;
    assign rdata = fe_rsp.rdata[hit_way];

    // processor holds its request steady while stalled
    assign miss_req   = (state_q == FE_MISS);
    assign miss_addr  = addr;
    assign miss_wen   = wen;
    assign miss_wdata = wdata;

    // a second matching way means install put one tag in twice
    assert property (@(posedge clk) disable iff (!rst_n)
        state_q == FE_LOOKUP |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

/* src/miss_handler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module miss_handler (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        miss_req,
    input  wire cache_pkg::paddr_t     miss_addr,
    input  wire cache_pkg::byte_en_t   miss_wen,
    input  wire cache_pkg::word_t      miss_wdata,
    output logic                       miss_done,
    output cache_pkg::store_req_t      mh_req,
    input  wire                        mh_grant,
    input  wire cache_pkg::store_rsp_t mh_rsp,
    output cache_pkg::mem_req_t        mem_req,
    input  wire cache_pkg::mem_rsp_t   mem_rsp
);
    import cache_pkg::*;

    localparam int LINE_WORDS = 1 << `CACHE_OFS_BITS;

    miss_state_t state_q;
    miss_state_t state_d;
    word_idx_t   beat_q;
    word_idx_t   beat_d;
    logic [1:0]  victim_q;
    logic [1:0]  victim_new;
    logic [1:0]  victim_sel;
    logic        victim_dirty;
    way_mask_t   victim_mask;
    tag_t        victim_tag_q;
    word_t       line_q [LINE_WORDS];
    tag_t        miss_tag;
    set_idx_t    miss_set;
    word_idx_t   miss_word;

    assign miss_tag  = miss_addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign miss_set  = miss_addr[2+`CACHE_OFS_BITS +: `CACHE_SET_BITS];
    assign miss_word = miss_addr[2 +: `CACHE_OFS_BITS];

    // empty way first, else follow the tree
    always_comb begin
        if (mh_rsp.hist[0])
            victim_new = mh_rsp.hist[2] ? 2'd3 : 2'd2;
        else
            victim_new = mh_rsp.hist[1] ? 2'd1 : 2'd0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            if (!mh_rsp.valid[w])
                victim_new = 2'(w);
        end
    end

    assign victim_dirty = mh_rsp.valid[victim_new] && mh_rsp.dirty[victim_new];
    assign victim_sel   = (beat_q == '0) ? victim_new : victim_q;
    assign victim_mask  = way_mask_t'(1) << victim_q;

    always_comb begin
        state_d        = state_q;
        beat_d         = beat_q;
        mh_req         = '0;
        mh_req.set     = miss_set;
        mh_req.word    = beat_q;
        mh_req.byte_en = 4'hf;
        mh_req.wdata   = mem_rsp.rdata;
        mh_req.tag     = miss_tag;
        mh_req.valid   = 1'b1;
        mh_req.dirty   = |miss_wen;
        mem_req        = '0;
        mem_req.awaddr = {victim_tag_q, miss_set, {(`CACHE_OFS_BITS+2){1'b0}}};
        mem_req.araddr = {miss_tag, miss_set, {(`CACHE_OFS_BITS+2){1'b0}}};
        mem_req.wdata  = line_q[beat_q];
        case (state_q)
            MS_IDLE: begin
                mh_req.req  = miss_req;
                mh_req.word = '0;
                beat_d      = '0;
                if (miss_req && mh_grant)
                    state_d = MS_LOOKUP;
            end
            MS_LOOKUP: begin
                if (beat_q == '0 && !victim_dirty) begin
                    state_d = MS_RF_ADDR;
                end else begin
                    // stream the rest of the dirty line into the buffer
                    beat_d      = beat_q + 1'b1;
                    mh_req.req  = (beat_q != '1);
                    mh_req.word = beat_q + 1'b1;
                    if (beat_q == '1)
                        state_d = MS_WB_ADDR;
                end
            end
            MS_WB_ADDR: begin
                mem_req.awvalid = 1'b1;
                if (mem_rsp.awready)
                    state_d = MS_WB_DATA;
            end
            MS_WB_DATA: begin
                mem_req.wvalid = 1'b1;
                mem_req.wlast  = (beat_q == '1);
                if (mem_rsp.wready) begin
                    beat_d = beat_q + 1'b1;
                    if (beat_q == '1)
                        state_d = MS_WB_RESP;
                end
            end
            MS_WB_RESP: begin
                mem_req.bready = 1'b1;
                if (mem_rsp.bvalid)
                    state_d = MS_RF_ADDR;
            end
            MS_RF_ADDR: begin
                mem_req.arvalid = 1'b1;
                if (mem_rsp.arready)
                    state_d = MS_RF_DATA;
            end
            MS_RF_DATA: begin
                mem_req.rready = 1'b1;
                if (mem_rsp.rvalid) begin
                    mh_req.req     = 1'b1;
                    mh_req.data_we = victim_mask;
                    beat_d         = beat_q + 1'b1;
                    if (mem_rsp.rlast)
                        state_d = MS_INSTALL;
                end
            end
            MS_INSTALL: begin
                // new tag, valid, dirty and the pending write bytes in one access
                mh_req.req      = 1'b1;
                mh_req.word     = miss_word;
                mh_req.wdata    = miss_wdata;
                mh_req.byte_en  = miss_wen;
                mh_req.data_we  = victim_mask;
                mh_req.tag_we   = victim_mask;
                mh_req.dirty_we = victim_mask;
                state_d         = MS_DONE;
            end
            default: state_d = MS_IDLE;
        endcase
    end

    assign miss_done = (state_q == MS_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MS_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
        end
    end

    // victim line held for the write-back burst
    always_ff @(posedge clk) begin
        if (state_q == MS_LOOKUP) begin
            line_q[beat_q] <= mh_rsp.rdata[victim_sel];
            if (beat_q == '0) begin
                victim_q     <= victim_new;
                victim_tag_q <= mh_rsp.tag[victim_new];
            end
        end
    end

    // a W beat stays up and unchanged until the slave takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.wvalid && !mem_rsp.wready |=> mem_req.wvalid && $stable(mem_req.wdata));

endmodule

`default_nettype wire

/* src/cache4way.sv */
`timescale 1ns/1ps
`default_nettype none

module cache4way (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      en,
    input  wire cache_pkg::paddr_t   addr,
    input  wire cache_pkg::byte_en_t wen,
    input  wire cache_pkg::word_t    wdata,
    output cache_pkg::word_t         rdata,
    output logic                     stall,
    output cache_pkg::mem_req_t      mem_req,
    input  wire cache_pkg::mem_rsp_t mem_rsp
);
    import cache_pkg::*;

    store_req_t fe_req;
    store_req_t mh_req;
    store_req_t st_req;
    store_rsp_t fe_rsp;
    store_rsp_t mh_rsp;
    store_rsp_t st_rsp;
    logic       fe_grant;
    logic       mh_grant;

    // miss handoff
    logic       miss_req;
    logic       miss_done;
    paddr_t     miss_addr;
    byte_en_t   miss_wen;
    word_t      miss_wdata;

    cache_frontend u_frontend (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .addr       (addr),
        .wen        (wen),
        .wdata      (wdata),
        .rdata      (rdata),
        .stall      (stall),
        .fe_req     (fe_req),
        .fe_grant   (fe_grant),
        .fe_rsp     (fe_rsp),
        .miss_req   (miss_req),
        .miss_addr  (miss_addr),
        .miss_wen   (miss_wen),
        .miss_wdata (miss_wdata),
        .miss_done  (miss_done)
    );

    miss_handler u_miss_handler (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss_req   (miss_req),
        .miss_addr  (miss_addr),
        .miss_wen   (miss_wen),
        .miss_wdata (miss_wdata),
        .miss_done  (miss_done),
        .mh_req     (mh_req),
        .mh_grant   (mh_grant),
        .mh_rsp     (mh_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    store_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .fe_req   (fe_req),
        .mh_req   (mh_req),
        .fe_grant (fe_grant),
        .mh_grant (mh_grant),
        .fe_rsp   (fe_rsp),
        .mh_rsp   (mh_rsp),
        .st_req   (st_req),
        .st_rsp   (st_rsp)
    );

    cache_store u_store (
        .clk    (clk),
        .rst_n  (rst_n),
        .st_req (st_req),
        .st_rsp (st_rsp)
    );

endmodule

`default_nettype wire

/* dv/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module mem_model #(
    parameter cache_pkg::word_t FILL_KEY = '0
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire cache_pkg::mem_req_t mem_req,
    output cache_pkg::mem_rsp_t      mem_rsp
);
    import cache_pkg::*;

    localparam int LINE_WORDS = 1 << `CACHE_OFS_BITS;

    // only words written by the cache are stored
    word_t  mem [paddr_t];
    logic   rd_busy;
    paddr_t rd_addr;
    int     rd_beat;
    logic   wr_busy;
    paddr_t wr_addr;
    int     wr_beat;
    logic   b_pend;

    function automatic word_t read_word(paddr_t a);
        paddr_t wa;
        wa = {a[`CACHE_ADDR_BITS-1:2], 2'b00};
        if (mem.exists(wa))
            return mem[wa];
        // untouched words are the address scrambled with a key
        return wa ^ FILL_KEY;
    endfunction

    // backdoor for the final memory compare
    task automatic peek_word(input paddr_t a, output word_t data);
        data = read_word(a);
    endtask

    // ready about three cycles in four
    function automatic logic coin();
        return ($urandom % 4) != 0;
    endfunction

    initial begin
        mem_rsp = '0;
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        b_pend  = 1'b0;
        rd_addr = '0;
        wr_addr = '0;
        rd_beat = 0;
        wr_beat = 0;
        forever begin
            // both sides are settled by mid cycle
            @(negedge clk);
            if (!rst_n) begin
                rd_busy = 1'b0;
                wr_busy = 1'b0;
                b_pend  = 1'b0;
                rd_beat = 0;
                wr_beat = 0;
            end else begin
                if (mem_req.arvalid && mem_rsp.arready) begin
                    rd_busy = 1'b1;
                    rd_addr = mem_req.araddr;
                    rd_beat = 0;
                end else if (mem_req.rready && mem_rsp.rvalid) begin
                    rd_beat++;
                    if (mem_rsp.rlast)
                        rd_busy = 1'b0;
                end
                if (mem_req.bready && mem_rsp.bvalid)
                    b_pend = 1'b0;
                if (mem_req.awvalid && mem_rsp.awready) begin
                    wr_busy = 1'b1;
                    wr_addr = mem_req.awaddr;
                    wr_beat = 0;
                end
                if (mem_req.wvalid && mem_rsp.wready) begin
                    mem[wr_addr + paddr_t'(4 * wr_beat)] = mem_req.wdata;
                    wr_beat++;
                    if (mem_req.wlast) begin
                        wr_busy = 1'b0;
                        b_pend  = 1'b1;
                    end
                end
            end
            @(posedge clk);
            #1;
            mem_rsp.arready = rst_n && !rd_busy && coin();
            mem_rsp.rvalid  = rd_busy && coin();
            mem_rsp.rdata   = read_word(rd_addr + paddr_t'(4 * rd_beat));
            mem_rsp.rlast   = rd_busy && (rd_beat == LINE_WORDS - 1);
            mem_rsp.awready = rst_n && !wr_busy && !b_pend && coin();
            mem_rsp.wready  = wr_busy && coin();
            mem_rsp.bvalid  = b_pend;
        end
    end

endmodule

`default_nettype wire

/* dv/tb_cache4way.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module tb_cache4way;
    import cache_pkg::*;

    localparam word_t FILL_KEY = 32'h5a3c_96e1;
    localparam tag_t  TAG_BASE = tag_t'('h400);
    localparam int    N_TAGS   = 24;
    localparam int    N_SETS   = 4;
    localparam int    N_RESET  = 16;
    localparam int    N_RANDOM = 300;
    localparam int    N_TIMING = 2;
    localparam int    N_REPL   = 9;
    localparam int    N_WB     = 80;
    localparam int    N_REQUESTS = N_RESET + N_RANDOM + N_TIMING + N_REPL + N_WB;
    localparam int    TIMEOUT_CYCLES = N_REQUESTS * 40 + 200;

    logic     clk;
    logic     rst_n;
    logic     en;
    paddr_t   addr;
    byte_en_t wen;
    word_t    wdata;
    word_t    rdata;
    logic     stall;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // reference model, data and tag state of sets 0..3
    word_t ref_mem [N_TAGS*N_SETS*4];
    tag_t  m_tag   [N_SETS][`CACHE_WAYS];
    logic  m_valid [N_SETS][`CACHE_WAYS];
    logic  m_dirty [N_SETS][`CACHE_WAYS];
    plru_t m_hist  [N_SETS];

    string cur_test;
    int    test_checks;
    int    test_errs;
    int    total_checks;
    int    total_errs;
    int    n_tests;
    int    cyc;

    cache4way dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .addr    (addr),
        .wen     (wen),
        .wdata   (wdata),
        .rdata   (rdata),
        .stall   (stall),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #5 clk = ~clk;

    function automatic paddr_t make_addr(int t, int s, int w);
        tag_t tg;
        tg = TAG_BASE + tag_t'(t);
        return {tg, set_idx_t'(s), word_idx_t'(w), 2'b00};
    endfunction

    function automatic int ref_index(int t, int s, int w);
        return (t * N_SETS + s) * 4 + w;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t nw, byte_en_t be);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                r[8*b +: 8] = nw[8*b +: 8];
        end
        return r;
    endfunction

    // bit 0 picks the pair, then bit 1 or bit 2 the way in it
    function automatic int tree_victim(plru_t h);
        if (h[0])
            return h[2] ? 3 : 2;
        return h[1] ? 1 : 0;
    endfunction

    function automatic plru_t point_away(plru_t h, int way);
        plru_t r;
        r = h;
        case (way)
            0: begin r[0] = 1'b1; r[1] = 1'b1; end
            1: begin r[0] = 1'b1; r[1] = 1'b0; end
            2: begin r[0] = 1'b0; r[2] = 1'b1; end
            default: begin r[0] = 1'b0; r[2] = 1'b0; end
        endcase
        return r;
    endfunction

    function automatic logic dirty_resident(int t, int s);
        tag_t tg;
        logic r;
        tg = TAG_BASE + tag_t'(t);
        r = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[s][w] && m_dirty[s][w] && m_tag[s][w] == tg)
                r = 1'b1;
        end
        return r;
    endfunction

    // predict hit or miss, then install and age like the cache
    task automatic model_access(input int t, input int s, input byte_en_t be,
                                output logic hit);
        tag_t tg;
        int   way;
        tg  = TAG_BASE + tag_t'(t);
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == tg) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = tree_victim(m_hist[s]);
            for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
                if (!m_valid[s][w])
                    way = w;
            end
            m_tag[s][way]   = tg;
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = 1'b0;
        end
        if (|be)
            m_dirty[s][way] = 1'b1;
        m_hist[s] = point_away(m_hist[s], way);
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        test_checks++;
        if (act !== exp) begin
            test_errs++;
            $display("MISMATCH %s: %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_hit(input string what, input logic exp, input logic act);
        test_checks++;
        if (act !== exp) begin
            test_errs++;
            $display("MISMATCH %s: %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_mem(input string what, input word_t exp, input word_t act);
        test_checks++;
        if (act !== exp) begin
            test_errs++;
            $display("MISMATCH %s: %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    // starts at posedge + 1 and ends there too
    task automatic access(input int t, input int s, input int w, input byte_en_t be,
                          input word_t data, output word_t rd, output int stall_cycles);
        logic finished;
        en           = 1'b1;
        addr         = make_addr(t, s, w);
        wen          = be;
        wdata        = data;
        stall_cycles = 0;
        finished     = 1'b0;
        rd           = '0;
        while (!finished) begin
            @(negedge clk);
            if (stall) begin
                stall_cycles++;
            end else begin
                rd       = rdata;
                finished = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        en  = 1'b0;
        wen = '0;
    endtask

    task automatic run_op(input int t, input int s, input int w, input byte_en_t be,
                          input word_t data, output int stall_cycles);
        logic  exp_hit;
        word_t rd;
        int    idx;
        idx = ref_index(t, s, w);
        model_access(t, s, be, exp_hit);
        access(t, s, w, be, data, rd, stall_cycles);
        check_hit($sformatf("hit at %h", make_addr(t, s, w)), exp_hit, stall_cycles == 1);
        if (be == '0)
            check_word($sformatf("read at %h", make_addr(t, s, w)), ref_mem[idx], rd);
        else
            ref_mem[idx] = merge_bytes(ref_mem[idx], data, be);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic finish_test();
        $display("%s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
        total_checks += test_checks;
        total_errs   += test_errs;
        n_tests++;
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES + 10) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        word_t    d;
        byte_en_t be;
        void'($urandom(75));
        clk   = 1'b0;
        rst_n = 1'b0;
        en    = 1'b0;
        addr  = '0;
        wen   = '0;
        wdata = '0;
        total_checks = 0;
        total_errs   = 0;
        n_tests      = 0;
        for (int t = 0; t < N_TAGS; t++)
            for (int s = 0; s < N_SETS; s++)
                for (int w = 0; w < 4; w++)
                    ref_mem[ref_index(t, s, w)] = make_addr(t, s, w) ^ FILL_KEY;
        for (int s = 0; s < N_SETS; s++) begin
            m_hist[s] = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        start_test("read_after_reset");
        repeat (N_RESET)
            run_op($urandom % 8, $urandom % N_SETS, $urandom % 4, 4'h0, '0, cyc);
        finish_test();

        start_test("reads_see_writes");
        for (int i = 0; i < N_RANDOM; i++) begin
            be = ($urandom % 2) ? byte_en_t'($urandom) : 4'h0;
            run_op($urandom % 8, $urandom % N_SETS, $urandom % 4, be, $urandom, cyc);
        end
        finish_test();

        // tag 13 is never touched by the random phases
        start_test("hit_timing");
        run_op(13, 1, 2, 4'h0, '0, cyc);
        check_hit("first access to a new line", 1'b0, cyc == 1);
        run_op(13, 1, 2, 4'h0, '0, cyc);
        check_hit("repeat access to the line", 1'b1, cyc == 1);
        finish_test();

        // five tags in set 2, then revisit the first four
        start_test("replacement");
        for (int t = 8; t <= 12; t++)
            run_op(t, 2, 0, 4'h0, '0, cyc);
        for (int t = 8; t <= 11; t++)
            run_op(t, 2, 0, 4'h0, '0, cyc);
        finish_test();

        start_test("write_back");
        for (int t = 0; t < 4; t++)
            for (int s = 0; s < N_SETS; s++)
                for (int w = 0; w < 4; w++)
                    run_op(t, s, w, byte_en_t'($urandom % 15 + 1), $urandom, cyc);
        // four fresh tags per set push every older line out
        for (int s = 0; s < N_SETS; s++)
            for (int t = 16; t < 20; t++)
                run_op(t, s, 1, 4'h0, '0, cyc);
        for (int t = 0; t < N_TAGS; t++) begin
            for (int s = 0; s < N_SETS; s++) begin
                if (!dirty_resident(t, s)) begin
                    for (int w = 0; w < 4; w++) begin
                        u_mem.peek_word(make_addr(t, s, w), d);
                        check_mem($sformatf("memory at %h", make_addr(t, s, w)),
                                  ref_mem[ref_index(t, s, w)], d);
                    end
                end
            end
        end
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, total_checks, total_errs);
        if (total_errs == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/cache_pkg.sv
src/cache_store.sv
src/store_arbiter.sv
src/cache_frontend.sv
src/miss_handler.sv
src/cache4way.sv
dv/mem_model.sv
dv/tb_cache4way.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache4way -f sim.f -o tb_cache4way
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_cache4way)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
